// File: common/pipe_ctrl_macros.svh
`ifndef PIPE_CTRL_MACROS_SVH
`define PIPE_CTRL_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths fixed by the RV32 ISA.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XLEN            32                      // Data and PC width.
`define REG_AW          5                       // Register index width, x0..x31.
`define CSR_AW          12                      // CSR address width.

// Trap CSR constants.
`define MTVEC_RESET     32'h0000_0100           // Trap vector after reset.
`define CAUSE_ECALL_M   32'd11                  // Environment call from M-mode.

`endif

// File: common/pipe_ctrl_pkg.sv
`include "pipe_ctrl_macros.svh"

package pipe_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand source chosen by the hazard unit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        FWD_REG      = 3'd0,                    // Register file value from decode.
        FWD_EX       = 3'd1,                    // ALU result still in EX.
        FWD_MEM_ALU  = 3'd2,                    // ALU result carried into MEM.
        FWD_MEM_LOAD = 3'd3,                    // Load data returned in MEM.
        FWD_WB       = 3'd4                     // Final write-back value.
    } fwd_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reason for a PC redirect.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        RD_NONE    = 3'd0,
        RD_JUMP    = 3'd1,                      // jal or jalr in EX.
        RD_BRANCH  = 3'd2,                      // Taken conditional branch in EX.
        RD_FENCE_I = 3'd3,                      // Instruction cache sync in EX.
        RD_ECALL   = 3'd4,                      // Trap entry from decode.
        RD_MRET    = 3'd5                       // Trap return from decode.
    } redirect_cause_e;

    // Machine trap CSRs handled here.
    typedef enum logic [`CSR_AW-1:0] {
        CSR_MTVEC  = 12'h305,
        CSR_MEPC   = 12'h341,
        CSR_MCAUSE = 12'h342
    } csr_addr_e;

endpackage

// File: common/stage_if.sv
`timescale 1ns/1ps
`include "pipe_ctrl_macros.svh"

// Write-back status of one in-flight pipeline stage.
interface stage_if;

    logic                   valid;              // Stage holds a live instruction.
    logic [`REG_AW-1:0]     rd;                 // Destination register index.
    logic                   reg_wen;            // Instruction writes rd.
    logic                   mem_ren;            // Instruction is a load.
    logic [`XLEN-1:0]       result;             // Value the stage can forward.

    modport src (
        output valid,
        output rd,
        output reg_wen,
        output mem_ren,
        output result
    );

    modport dst (
        input  valid,
        input  rd,
        input  reg_wen,
        input  mem_ren,
        input  result
    );

endinterface

// File: design/hazard/hazard_unit.sv
`timescale 1ns/1ps
`include "pipe_ctrl_macros.svh"

module hazard_unit (
    stage_if.dst                        ex,
    stage_if.dst                        mem,
    stage_if.dst                        wb,
    input  logic [`XLEN-1:0]            mem_rdata,
    input  logic                        id_valid,
    input  logic [`REG_AW-1:0]          id_rs1,
    input  logic [`REG_AW-1:0]          id_rs2,
    input  logic [`XLEN-1:0]            rs1_value,
    input  logic [`XLEN-1:0]            rs2_value,
    output logic [`XLEN-1:0]            rs1_fwd,
    output logic [`XLEN-1:0]            rs2_fwd,
    output pipe_ctrl_pkg::fwd_sel_e     rs1_sel,
    output pipe_ctrl_pkg::fwd_sel_e     rs2_sel,
    output logic                        load_use_stall
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers shared by both operands.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic rd_match(
        input logic                 valid,
        input logic                 reg_wen,
        input logic [`REG_AW-1:0]   rd,
        input logic [`REG_AW-1:0]   rs
    );
        rd_match = valid && reg_wen && (rd != '0) && (rd == rs);   // x0 never forwards.
    endfunction

    // Youngest producer wins.
    function automatic pipe_ctrl_pkg::fwd_sel_e pick_src(
        input logic ex_hit,
        input logic mem_hit,
        input logic wb_hit,
        input logic mem_load
    );
        if (ex_hit)
            pick_src = pipe_ctrl_pkg::FWD_EX;
        else if (mem_hit)
            pick_src = mem_load ? pipe_ctrl_pkg::FWD_MEM_LOAD : pipe_ctrl_pkg::FWD_MEM_ALU;
        else if (wb_hit)
            pick_src = pipe_ctrl_pkg::FWD_WB;
        else
            pick_src = pipe_ctrl_pkg::FWD_REG;
    endfunction

    function automatic logic [`XLEN-1:0] fwd_mux(
        input pipe_ctrl_pkg::fwd_sel_e  sel,
        input logic [`XLEN-1:0]         reg_val,
        input logic [`XLEN-1:0]         ex_val,
        input logic [`XLEN-1:0]         mem_alu_val,
        input logic [`XLEN-1:0]         mem_load_val,
        input logic [`XLEN-1:0]         wb_val
    );
        case (sel)
            pipe_ctrl_pkg::FWD_EX:       fwd_mux = ex_val;
            pipe_ctrl_pkg::FWD_MEM_ALU:  fwd_mux = mem_alu_val;
            pipe_ctrl_pkg::FWD_MEM_LOAD: fwd_mux = mem_load_val;
            pipe_ctrl_pkg::FWD_WB:       fwd_mux = wb_val;
            default:                     fwd_mux = reg_val;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forwarding.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic rs1_ex_hit;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_ex_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;

    assign rs1_ex_hit  = rd_match(ex.valid,  ex.reg_wen,  ex.rd,  id_rs1);
    assign rs1_mem_hit = rd_match(mem.valid, mem.reg_wen, mem.rd, id_rs1);
    assign rs1_wb_hit  = rd_match(wb.valid,  wb.reg_wen,  wb.rd,  id_rs1);
    assign rs2_ex_hit  = rd_match(ex.valid,  ex.reg_wen,  ex.rd,  id_rs2);
    assign rs2_mem_hit = rd_match(mem.valid, mem.reg_wen, mem.rd, id_rs2);
    assign rs2_wb_hit  = rd_match(wb.valid,  wb.reg_wen,  wb.rd,  id_rs2);

    assign rs1_sel = pick_src(rs1_ex_hit, rs1_mem_hit, rs1_wb_hit, mem.mem_ren);
    assign rs2_sel = pick_src(rs2_ex_hit, rs2_mem_hit, rs2_wb_hit, mem.mem_ren);

    assign rs1_fwd = fwd_mux(rs1_sel, rs1_value, ex.result, mem.result, mem_rdata, wb.result);
    assign rs2_fwd = fwd_mux(rs2_sel, rs2_value, ex.result, mem.result, mem_rdata, wb.result);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load-use stall.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic ex_load;

    // A load in EX has only its address, the data arrives one stage later.
    assign ex_load        = ex.valid && ex.mem_ren && (ex.rd != '0);
    assign load_use_stall = id_valid && ex_load && ((ex.rd == id_rs1) || (ex.rd == id_rs2));

endmodule

// File: design/redirect/redirect_unit.sv
`timescale 1ns/1ps
`include "pipe_ctrl_macros.svh"

module redirect_unit (
    input  logic                                ex_valid,
    input  logic                                jump_flag,
    input  logic                                branch_flag,
    input  logic                                branch_taken,
    input  logic                                fence_i_flag,
    input  logic [`XLEN-1:0]                    ex_pc,
    input  logic [`XLEN-1:0]                    ex_imm,
    input  logic                                id_valid,
    input  logic                                ecall_flag,
    input  logic                                mret_flag,
    input  logic [`XLEN-1:0]                    mtvec,
    input  logic [`XLEN-1:0]                    mepc,
    output logic                                redirect_valid,
    output logic                                icache_clr,
    output logic                                trap_take,
    output logic [`XLEN-1:0]                    redirect_pc,
    output pipe_ctrl_pkg::redirect_cause_e      redirect_cause
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Qualified events per stage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic ex_jump;
    logic ex_branch;
    logic ex_fence_i;
    logic id_ecall;
    logic id_mret;

    assign ex_jump    = ex_valid && jump_flag;
    assign ex_branch  = ex_valid && branch_flag && branch_taken;    // Not-taken falls through.
    assign ex_fence_i = ex_valid && fence_i_flag;
    assign id_ecall   = id_valid && ecall_flag;
    assign id_mret    = id_valid && mret_flag;

    // EX holds the older instruction, so its event beats anything in decode.
    always_comb begin
        if (ex_jump)
            redirect_cause = pipe_ctrl_pkg::RD_JUMP;
        else if (ex_branch)
            redirect_cause = pipe_ctrl_pkg::RD_BRANCH;
        else if (ex_fence_i)
            redirect_cause = pipe_ctrl_pkg::RD_FENCE_I;
        else if (id_ecall)
            redirect_cause = pipe_ctrl_pkg::RD_ECALL;
        else if (id_mret)
            redirect_cause = pipe_ctrl_pkg::RD_MRET;
        else
            redirect_cause = pipe_ctrl_pkg::RD_NONE;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Target and side effects.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (redirect_cause)
            pipe_ctrl_pkg::RD_JUMP,
            pipe_ctrl_pkg::RD_BRANCH:  redirect_pc = ex_pc + ex_imm;
            pipe_ctrl_pkg::RD_FENCE_I: redirect_pc = ex_pc + `XLEN'd4;  // Refetch after the fence.
            pipe_ctrl_pkg::RD_ECALL:   redirect_pc = mtvec;
            pipe_ctrl_pkg::RD_MRET:    redirect_pc = mepc;
            default:                   redirect_pc = '0;
        endcase
    end

    // One level both redirects fetch and flushes decode.
    assign redirect_valid = (redirect_cause != pipe_ctrl_pkg::RD_NONE);
    assign icache_clr     = (redirect_cause == pipe_ctrl_pkg::RD_FENCE_I);
    assign trap_take      = (redirect_cause == pipe_ctrl_pkg::RD_ECALL);

endmodule

// File: design/redirect/trap_csr.sv
`timescale 1ns/1ps
`include "pipe_ctrl_macros.svh"

module trap_csr (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    trap_take,
    input  logic [`XLEN-1:0]        trap_pc,
    input  logic                    csr_wen,
    input  logic [`CSR_AW-1:0]      csr_addr,
    input  logic [`XLEN-1:0]        csr_wdata,
    input  logic [`CSR_AW-1:0]      csr_raddr,
    output logic [`XLEN-1:0]        csr_rdata,
    output logic [`XLEN-1:0]        mtvec,
    output logic [`XLEN-1:0]        mepc
);

    logic [`XLEN-1:0] mcause;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic [`XLEN-1:0] wdata_aligned;

    assign wr_mtvec  = csr_wen && (csr_addr == pipe_ctrl_pkg::CSR_MTVEC);
    assign wr_mepc   = csr_wen && (csr_addr == pipe_ctrl_pkg::CSR_MEPC);
    assign wr_mcause = csr_wen && (csr_addr == pipe_ctrl_pkg::CSR_MCAUSE);

    // Direct mode only, so mtvec and mepc stay word aligned.
    assign wdata_aligned = {csr_wdata[`XLEN-1:2], 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec <= `MTVEC_RESET;
        end else if (wr_mtvec) begin
            mtvec <= wdata_aligned;             // Traps never touch mtvec.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (trap_take) begin
            mepc <= trap_pc;                    // PC of the ecall itself.
        end else if (wr_mepc) begin
            mepc <= wdata_aligned;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (trap_take) begin
            mcause <= `CAUSE_ECALL_M;
        end else if (wr_mcause) begin
            mcause <= csr_wdata;
        end
    end

    // Combinational read port, unmapped addresses return zero.
    always_comb begin
        case (csr_raddr)
            pipe_ctrl_pkg::CSR_MTVEC:  csr_rdata = mtvec;
            pipe_ctrl_pkg::CSR_MEPC:   csr_rdata = mepc;
            pipe_ctrl_pkg::CSR_MCAUSE: csr_rdata = mcause;
            default:                   csr_rdata = '0;
        endcase
    end

endmodule

// File: design/pipe_ctrl_top.sv
`timescale 1ns/1ps
`include "pipe_ctrl_macros.svh"

module pipe_ctrl_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // Decode stage.
    input  logic                                id_valid,
    input  logic [`XLEN-1:0]                    id_pc,
    input  logic [`REG_AW-1:0]                  id_rs1,
    input  logic [`REG_AW-1:0]                  id_rs2,
    input  logic [`XLEN-1:0]                    rs1_value,
    input  logic [`XLEN-1:0]                    rs2_value,
    input  logic                                ecall_flag,
    input  logic                                mret_flag,
    // Execute stage.
    input  logic                                ex_valid,
    input  logic [`REG_AW-1:0]                  ex_rd,
    input  logic                                ex_reg_wen,
    input  logic                                ex_mem_ren,
    input  logic [`XLEN-1:0]                    ex_result,
    input  logic [`XLEN-1:0]                    ex_pc,
    input  logic [`XLEN-1:0]                    ex_imm,
    input  logic                                jump_flag,
    input  logic                                branch_flag,
    input  logic                                branch_taken,
    input  logic                                fence_i_flag,
    // Memory stage.
    input  logic                                mem_valid,
    input  logic [`REG_AW-1:0]                  mem_rd,
    input  logic                                mem_reg_wen,
    input  logic                                mem_mem_ren,
    input  logic [`XLEN-1:0]                    mem_result,
    input  logic [`XLEN-1:0]                    mem_rdata,
    // Write-back stage.
    input  logic                                wb_valid,
    input  logic [`REG_AW-1:0]                  wb_rd,
    input  logic                                wb_reg_wen,
    input  logic [`XLEN-1:0]                    wb_result,
    // CSR port.
    input  logic                                csr_wen,
    input  logic [`CSR_AW-1:0]                  csr_addr,
    input  logic [`XLEN-1:0]                    csr_wdata,
    input  logic [`CSR_AW-1:0]                  csr_raddr,
    // Results.
    output logic [`XLEN-1:0]                    rs1_fwd,
    output logic [`XLEN-1:0]                    rs2_fwd,
    output logic                                load_use_stall,
    output logic                                redirect_valid,
    output logic [`XLEN-1:0]                    redirect_pc,
    output pipe_ctrl_pkg::redirect_cause_e      redirect_cause,
    output logic                                icache_clr,
    output logic [`XLEN-1:0]                    csr_rdata
);

    pipe_ctrl_pkg::fwd_sel_e    rs1_sel;        // Observed by the bound checks.
    pipe_ctrl_pkg::fwd_sel_e    rs2_sel;
    logic                       trap_take;
    logic [`XLEN-1:0]           mtvec;
    logic [`XLEN-1:0]           mepc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage status bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    stage_if ex_stage ();
    stage_if mem_stage ();
    stage_if wb_stage ();

    assign ex_stage.valid    = ex_valid;
    assign ex_stage.rd       = ex_rd;
    assign ex_stage.reg_wen  = ex_reg_wen;
    assign ex_stage.mem_ren  = ex_mem_ren;
    assign ex_stage.result   = ex_result;

    assign mem_stage.valid   = mem_valid;
    assign mem_stage.rd      = mem_rd;
    assign mem_stage.reg_wen = mem_reg_wen;
    assign mem_stage.mem_ren = mem_mem_ren;
    assign mem_stage.result  = mem_result;

    assign wb_stage.valid    = wb_valid;
    assign wb_stage.rd       = wb_rd;
    assign wb_stage.reg_wen  = wb_reg_wen;
    assign wb_stage.mem_ren  = 1'b0;            // Loads are resolved by write-back.
    assign wb_stage.result   = wb_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Blocks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    hazard_unit u_hazard (
        .ex             (ex_stage.dst),
        .mem            (mem_stage.dst),
        .wb             (wb_stage.dst),
        .mem_rdata      (mem_rdata),
        .id_valid       (id_valid),
        .id_rs1         (id_rs1),
        .id_rs2         (id_rs2),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .rs1_fwd        (rs1_fwd),
        .rs2_fwd        (rs2_fwd),
        .rs1_sel        (rs1_sel),
        .rs2_sel        (rs2_sel),
        .load_use_stall (load_use_stall)
    );

    redirect_unit u_redirect (
        .ex_valid       (ex_valid),
        .jump_flag      (jump_flag),
        .branch_flag    (branch_flag),
        .branch_taken   (branch_taken),
        .fence_i_flag   (fence_i_flag),
        .ex_pc          (ex_pc),
        .ex_imm         (ex_imm),
        .id_valid       (id_valid),
        .ecall_flag     (ecall_flag),
        .mret_flag      (mret_flag),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .redirect_valid (redirect_valid),
        .icache_clr     (icache_clr),
        .trap_take      (trap_take),
        .redirect_pc    (redirect_pc),
        .redirect_cause (redirect_cause)
    );

    trap_csr u_trap_csr (
        .clk            (clk),
        .rst_n          (rst_n),
        .trap_take      (trap_take),
        .trap_pc        (id_pc),                // ecall sits in decode.
        .csr_wen        (csr_wen),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata),
        .mtvec          (mtvec),
        .mepc           (mepc)
    );

endmodule

// File: test/pipe_ctrl_assert.sv
`timescale 1ns/1ps

module pipe_ctrl_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     ex_valid,
    input logic                     id_valid,
    input logic [4:0]               ex_rd,
    input logic                     ex_mem_ren,
    input pipe_ctrl_pkg::fwd_sel_e  rs1_sel,
    input pipe_ctrl_pkg::fwd_sel_e  rs2_sel,
    input logic                     icache_clr,
    input logic                     redirect_valid,
    input logic                     load_use_stall
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Redirect and stall properties.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_clr_needs_redirect: assert property (
        @(posedge clk) disable iff (!rst_n) icache_clr |-> redirect_valid
    ) else $error("icache_clr without redirect_valid");

    a_stall_nonzero_rd: assert property (
        @(posedge clk) disable iff (!rst_n) load_use_stall |-> (ex_rd != 5'd0)
    ) else $error("load_use_stall with x0 as the EX destination");

    // Only a live EX or decode instruction can redirect.
    a_idle_no_redirect: assert property (
        @(posedge clk) disable iff (!rst_n) (!ex_valid && !id_valid) |-> !redirect_valid
    ) else $error("redirect_valid while EX and decode are empty");

    // Forwarding a load from EX hands decode an address and must come with a stall.
    a_ex_load_fwd_stalls: assert property (
        @(posedge clk) disable iff (!rst_n)
            (id_valid && ex_mem_ren &&
             (rs1_sel == pipe_ctrl_pkg::FWD_EX || rs2_sel == pipe_ctrl_pkg::FWD_EX))
            |-> load_use_stall
    ) else $error("EX load forwarded to decode without load_use_stall");

endmodule

bind pipe_ctrl_top pipe_ctrl_assert i_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid       (ex_valid),
    .id_valid       (id_valid),
    .ex_rd          (ex_rd),
    .ex_mem_ren     (ex_mem_ren),
    .rs1_sel        (rs1_sel),
    .rs2_sel        (rs2_sel),
    .icache_clr     (icache_clr),
    .redirect_valid (redirect_valid),
    .load_use_stall (load_use_stall)
);

// File: test/pipe_ctrl_tb.sv
`timescale 1ns/1ps
`include "pipe_ctrl_macros.svh"

module pipe_ctrl_tb;

    localparam int N_ROWS      = 21;
    localparam int RAND_CYCLES = 200;
    localparam int WATCHDOG_NS = (N_ROWS + RAND_CYCLES + 20) * 20;

    // Each source drives a distinct value so the chosen one is visible.
    localparam logic [31:0] V_RS1  = 32'h1111_1111;
    localparam logic [31:0] V_RS2  = 32'h2222_2222;
    localparam logic [31:0] V_EX   = 32'heeee_0001;
    localparam logic [31:0] V_MALU = 32'haaaa_0002;
    localparam logic [31:0] V_LD   = 32'hdddd_0003;
    localparam logic [31:0] V_WB   = 32'hbbbb_0004;

    typedef struct packed {
        logic        id_valid, ecall, mret;
        logic        ex_valid, ex_wen, ex_ren;
        logic        jump, branch, taken, fence;
        logic        mem_valid, mem_wen, mem_ren;
        logic        wb_valid, wb_wen, csr_wen;
        logic [4:0]  rs1, rs2, ex_rd, mem_rd, wb_rd;
        logic [11:0] csr_addr, csr_raddr;
        logic [31:0] id_pc, ex_pc, ex_imm, csr_wdata;
        logic [31:0] e_rs1, e_rs2, e_rpc, e_csr;
        logic        e_stall, e_rv, e_icache;
        pipe_ctrl_pkg::redirect_cause_e e_cause;
    } row_t;

    row_t        rows[$];
    logic [31:0] rng_state = 32'hb4f1_3879;

    logic clk = 1'b0;
    logic rst_n, id_valid, ecall_flag, mret_flag, ex_valid, ex_reg_wen, ex_mem_ren;
    logic jump_flag, branch_flag, branch_taken, fence_i_flag;
    logic mem_valid, mem_reg_wen, mem_mem_ren, wb_valid, wb_reg_wen, csr_wen;
    logic [4:0]  id_rs1, id_rs2, ex_rd, mem_rd, wb_rd;
    logic [31:0] id_pc, rs1_value, rs2_value, ex_result, ex_pc, ex_imm;
    logic [31:0] mem_result, mem_rdata, wb_result, csr_wdata;
    logic [11:0] csr_addr, csr_raddr;
    logic [31:0] rs1_fwd, rs2_fwd, redirect_pc, csr_rdata;
    logic        load_use_stall, redirect_valid, icache_clr;
    pipe_ctrl_pkg::redirect_cause_e redirect_cause;

    pipe_ctrl_top i_dut (.*);

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Youngest writing stage with a matching nonzero rd, else the register value.
    function automatic logic [31:0] fwd_model(input logic [4:0] rs, input logic [31:0] reg_val);
        if (rs == 5'd0)
            return reg_val;
        if (ex_valid && ex_reg_wen && ex_rd == rs)
            return ex_result;
        if (mem_valid && mem_reg_wen && mem_rd == rs)
            return mem_mem_ren ? mem_rdata : mem_result;
        if (wb_valid && wb_reg_wen && wb_rd == rs)
            return wb_result;
        return reg_val;
    endfunction

    // Decode waits on a valid EX load whose rd is one of its nonzero sources.
    function automatic logic stall_model();
        logic rs1_dep;
        logic rs2_dep;
        rs1_dep = (id_rs1 != 5'd0) && (id_rs1 == ex_rd);
        rs2_dep = (id_rs2 != 5'd0) && (id_rs2 == ex_rd);
        return id_valid && ex_valid && ex_mem_ren && (rs1_dep || rs2_dep);
    endfunction

    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.e_rs1 = V_RS1;
        r.e_rs2 = V_RS2;
        r.e_cause = pipe_ctrl_pkg::RD_NONE;
        return r;
    endfunction

    task automatic add_fwd(input int idv, input int rs1, input int rs2,
                           input int exv, input int exrd, input int exwen, input int exren,
                           input int mv, input int mrd, input int mwen, input int mren,
                           input int wv, input int wrd, input int wwen,
                           input logic [31:0] e1, input logic [31:0] e2, input int est);
        row_t r;
        r = blank_row();
        r.id_valid = idv[0];
        r.rs1 = rs1[4:0];
        r.rs2 = rs2[4:0];
        r.ex_valid = exv[0];
        r.ex_rd = exrd[4:0];
        r.ex_wen = exwen[0];
        r.ex_ren = exren[0];
        r.mem_valid = mv[0];
        r.mem_rd = mrd[4:0];
        r.mem_wen = mwen[0];
        r.mem_ren = mren[0];
        r.wb_valid = wv[0];
        r.wb_rd = wrd[4:0];
        r.wb_wen = wwen[0];
        r.e_rs1 = e1;
        r.e_rs2 = e2;
        r.e_stall = est[0];
        rows.push_back(r);
    endtask

    task automatic add_redir(input int exv, input int jmp, input int br, input int tk,
                             input int fen, input logic [31:0] pc, input logic [31:0] imm,
                             input int idv, input int ec, input int mr, input logic [31:0] ipc,
                             input int erv, input logic [31:0] erpc, input int eic,
                             input pipe_ctrl_pkg::redirect_cause_e ecause);
        row_t r;
        r = blank_row();
        r.ex_valid = exv[0];
        r.jump = jmp[0];
        r.branch = br[0];
        r.taken = tk[0];
        r.fence = fen[0];
        r.ex_pc = pc;
        r.ex_imm = imm;
        r.id_valid = idv[0];
        r.ecall = ec[0];
        r.mret = mr[0];
        r.id_pc = ipc;
        r.e_rv = erv[0];
        r.e_rpc = erpc;
        r.e_icache = eic[0];
        r.e_cause = ecause;
        rows.push_back(r);
    endtask

    task automatic add_csr(input int wen, input logic [11:0] addr, input logic [31:0] wdata,
                           input logic [11:0] raddr, input logic [31:0] e_csr);
        row_t r;
        r = blank_row();
        r.csr_wen = wen[0];
        r.csr_addr = addr;
        r.csr_wdata = wdata;
        r.csr_raddr = raddr;
        r.e_csr = e_csr;
        rows.push_back(r);
    endtask

    task automatic read_on_last(input logic [11:0] raddr, input logic [31:0] e_csr);
        rows[rows.size() - 1].csr_raddr = raddr;
        rows[rows.size() - 1].e_csr = e_csr;
    endtask

    task automatic apply_row(input row_t r);
        {id_valid, id_pc, id_rs1, id_rs2, ecall_flag, mret_flag} =
            {r.id_valid, r.id_pc, r.rs1, r.rs2, r.ecall, r.mret};
        {ex_valid, ex_rd, ex_reg_wen, ex_mem_ren, ex_pc, ex_imm} =
            {r.ex_valid, r.ex_rd, r.ex_wen, r.ex_ren, r.ex_pc, r.ex_imm};
        {jump_flag, branch_flag, branch_taken, fence_i_flag} =
            {r.jump, r.branch, r.taken, r.fence};
        {mem_valid, mem_rd, mem_reg_wen, mem_mem_ren} =
            {r.mem_valid, r.mem_rd, r.mem_wen, r.mem_ren};
        {wb_valid, wb_rd, wb_reg_wen} = {r.wb_valid, r.wb_rd, r.wb_wen};
        {csr_wen, csr_addr, csr_wdata, csr_raddr} =
            {r.csr_wen, r.csr_addr, r.csr_wdata, r.csr_raddr};
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rv;
        row_t r;
        rst_n = 1'b0;
        apply_row(blank_row());
        {rs1_value, rs2_value, ex_result} = {V_RS1, V_RS2, V_EX};
        {mem_result, mem_rdata, wb_result} = {V_MALU, V_LD, V_WB};

        add_csr(0, 12'h0, 32'h0, pipe_ctrl_pkg::CSR_MTVEC, `MTVEC_RESET);   // Reset values.
        add_csr(0, 12'h0, 32'h0, pipe_ctrl_pkg::CSR_MEPC, 32'h0);
        add_csr(0, 12'h0, 32'h0, pipe_ctrl_pkg::CSR_MCAUSE, 32'h0);
        add_fwd(1, 5, 6, 1, 5, 1, 0, 1, 5, 1, 0, 1, 6, 1, V_EX, V_WB, 0);
        add_fwd(1, 5, 7, 0, 0, 0, 0, 1, 5, 1, 1, 1, 5, 1, V_LD, V_RS2, 0);
        add_fwd(1, 5, 6, 0, 0, 0, 0, 1, 5, 1, 0, 1, 6, 1, V_MALU, V_WB, 0);
        add_fwd(1, 0, 4, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, V_RS1, V_RS2, 0);
        add_fwd(1, 5, 0, 1, 5, 0, 0, 1, 5, 0, 0, 1, 5, 1, V_WB, V_RS2, 0);
        add_fwd(1, 3, 9, 1, 9, 1, 1, 0, 0, 0, 0, 0, 0, 0, V_RS1, V_EX, 1);  // Load-use.
        add_fwd(0, 3, 9, 1, 9, 1, 1, 0, 0, 0, 0, 0, 0, 0, V_RS1, V_EX, 0);
        add_fwd(1, 0, 0, 1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, V_RS1, V_RS2, 0);
        add_redir(1, 1, 0, 0, 0, 32'h1000, 32'h40, 0, 0, 0, 0, 1, 32'h1040, 0,
                  pipe_ctrl_pkg::RD_JUMP);
        add_redir(1, 0, 1, 1, 0, 32'h2000, 32'hffff_fff0, 0, 0, 0, 0, 1, 32'h1ff0, 0,
                  pipe_ctrl_pkg::RD_BRANCH);
        add_redir(1, 0, 1, 0, 0, 32'h2000, 32'h10, 0, 0, 0, 0, 0, 32'h0, 0,
                  pipe_ctrl_pkg::RD_NONE);
        add_redir(1, 0, 0, 0, 1, 32'h3000, 32'h0, 0, 0, 0, 0, 1, 32'h3004, 1,
                  pipe_ctrl_pkg::RD_FENCE_I);
        add_redir(1, 1, 0, 0, 0, 32'h4000, 32'h8, 1, 1, 0, 32'h4444, 1, 32'h4008, 0,
                  pipe_ctrl_pkg::RD_JUMP);
        add_csr(1, pipe_ctrl_pkg::CSR_MTVEC, 32'h203, pipe_ctrl_pkg::CSR_MTVEC, `MTVEC_RESET);
        add_redir(0, 0, 0, 0, 0, 32'h0, 32'h0, 1, 1, 0, 32'h5000, 1, 32'h200, 0,
                  pipe_ctrl_pkg::RD_ECALL);
        read_on_last(pipe_ctrl_pkg::CSR_MTVEC, 32'h200);
        add_csr(0, 12'h0, 32'h0, pipe_ctrl_pkg::CSR_MEPC, 32'h5000);
        add_redir(0, 0, 0, 0, 0, 32'h0, 32'h0, 1, 0, 1, 32'h5004, 1, 32'h5000, 0,
                  pipe_ctrl_pkg::RD_MRET);
        read_on_last(pipe_ctrl_pkg::CSR_MCAUSE, `CAUSE_ECALL_M);
        add_redir(0, 1, 0, 0, 0, 32'h6000, 32'h4, 0, 0, 0, 0, 0, 32'h0, 0,
                  pipe_ctrl_pkg::RD_NONE);

        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        foreach (rows[i]) begin
            @(posedge clk);
            #2 apply_row(rows[i]);
            #15;
            check("rs1_fwd", rs1_fwd, rows[i].e_rs1);
            check("rs2_fwd", rs2_fwd, rows[i].e_rs2);
            check("load_use_stall", 32'(load_use_stall), 32'(rows[i].e_stall));
            check("redirect_valid", 32'(redirect_valid), 32'(rows[i].e_rv));
            if (rows[i].e_rv)
                check("redirect_pc", redirect_pc, rows[i].e_rpc);
            check("redirect_cause", 32'(redirect_cause), 32'(rows[i].e_cause));
            check("icache_clr", 32'(icache_clr), 32'(rows[i].e_icache));
            check("csr_rdata", csr_rdata, rows[i].e_csr);
        end

        // Random forwarding with small register indices so stages collide often.
        repeat (RAND_CYCLES) begin
            @(posedge clk);
            rv = next_rand();
            r = blank_row();
            r.id_valid = rv[0];
            r.rs1 = {2'b00, rv[3:1]};
            r.rs2 = {2'b00, rv[6:4]};
            {r.ex_valid, r.ex_wen, r.ex_ren, r.ex_rd} = {rv[7], rv[8], rv[9], 2'b00, rv[12:10]};
            {r.mem_valid, r.mem_wen, r.mem_ren, r.mem_rd} =
                {rv[13], rv[14], rv[15], 2'b00, rv[18:16]};
            {r.wb_valid, r.wb_wen, r.wb_rd} = {rv[19], rv[20], 2'b00, rv[23:21]};
            #2 apply_row(r);
            #15;
            check("rs1_fwd", rs1_fwd, fwd_model(id_rs1, rs1_value));
            check("rs2_fwd", rs2_fwd, fwd_model(id_rs2, rs2_value));
            check("load_use_stall", 32'(load_use_stall), 32'(stall_model()));
            check("redirect_valid", 32'(redirect_valid), 32'(1'b0));
        end

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish in %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: build.f
+incdir+common
common/pipe_ctrl_pkg.sv
common/stage_if.sv
design/hazard/hazard_unit.sv
design/redirect/redirect_unit.sv
design/redirect/trap_csr.sv
design/pipe_ctrl_top.sv
test/pipe_ctrl_assert.sv
test/pipe_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status is the simulator's.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module pipe_ctrl_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/Vpipe_ctrl_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
